// File: verilog/trigger_xbar_pkg.sv
package trigger_xbar_pkg;

	// ==============================
	// sizes
	// ==============================
	localparam int n_inputs   = 6;  // ext pins 0-3, l1a, self trigger
	localparam int n_outputs  = 9;  // ext pins 0-3, self trigger in, encoder ext_l1a 0-3
	localparam int n_external = 4;
	localparam int n_links    = 16;
	localparam int addr_w     = 11;
	localparam int data_w     = 32;
	localparam int sel_w      = 4;
	localparam int idx_w      = $clog2(n_links);

	localparam logic [sel_w-1:0] sel_quiet = 4'd6;  // anything >= n_inputs routes a constant 0

	// ==============================
	// register layout
	// ==============================
	typedef struct packed {
		logic [14:0]      padding_high;
		logic             direction;     // 1 = input, driver off
		logic [11:0]      padding_low;
		logic [sel_w-1:0] input_select;
	} link_param_t;

	typedef link_param_t [n_links-1:0] link_table_t;

	typedef struct packed {
		logic                wr;
		logic                rd;
		logic [idx_w-1:0]    index;
		logic [data_w-1:0]   wdata;
		logic [data_w/8-1:0] strb;
	} reg_access_t;

	typedef enum logic [1:0] {axi_okay = 2'b00, axi_slverr = 2'b10} axi_resp_e;
	typedef enum logic {w_idle, w_resp} wr_state_e;
	typedef enum logic {r_idle, r_data} rd_state_e;

	function automatic link_param_t input_link(logic [sel_w-1:0] sel);
		link_param_t link;
		link = '0;
		link.direction = 1'b1;
		link.input_select = sel;
		return link;
	endfunction

	// link 15 first, link 0 last
	localparam link_table_t link_defaults = {
		input_link(4'd0), input_link(4'd0), input_link(4'd0), input_link(4'd0),
		input_link(4'd0), input_link(4'd0), input_link(4'd0), input_link(4'd0),
		input_link(4'd3), input_link(4'd2), input_link(4'd1), input_link(sel_quiet),
		input_link(sel_quiet), input_link(sel_quiet), input_link(sel_quiet), input_link(sel_quiet)
	};

endpackage

// File: verilog/axil_reg_slave.sv
`timescale 1ns/100ps

module axil_reg_slave (
	input  logic                                     s_axi_aclk,
	input  logic                                     reset,
	input  logic [trigger_xbar_pkg::addr_w-1:0]      s_axi_awaddr,
	input  logic                                     s_axi_awvalid,
	output logic                                     s_axi_awready,
	input  logic [trigger_xbar_pkg::data_w-1:0]      s_axi_wdata,
	input  logic [trigger_xbar_pkg::data_w/8-1:0]    s_axi_wstrb,
	input  logic                                     s_axi_wvalid,
	output logic                                     s_axi_wready,
	output logic [1:0]                               s_axi_bresp,
	output logic                                     s_axi_bvalid,
	input  logic                                     s_axi_bready,
	input  logic [trigger_xbar_pkg::addr_w-1:0]      s_axi_araddr,
	input  logic                                     s_axi_arvalid,
	output logic                                     s_axi_arready,
	output logic [trigger_xbar_pkg::data_w-1:0]      s_axi_rdata,
	output logic [1:0]                               s_axi_rresp,
	output logic                                     s_axi_rvalid,
	input  logic                                     s_axi_rready,
	output trigger_xbar_pkg::reg_access_t            access,
	input  logic [trigger_xbar_pkg::data_w-1:0]      rd_data
);
	import trigger_xbar_pkg::*;

	wr_state_e wr_state;
	rd_state_e rd_state;
	axi_resp_e bresp_q;
	axi_resp_e rresp_q;
	logic      rd_in_range_q;
	logic      wr_accept;
	logic      rd_accept;
	logic      aw_in_range;
	logic      ar_in_range;

	// ==============================
	// address decode
	// ==============================
	// word registers live below byte address n_links*4
	assign aw_in_range = (s_axi_awaddr[addr_w-1:idx_w+2] == '0);
	assign ar_in_range = (s_axi_araddr[addr_w-1:idx_w+2] == '0);

	// ==============================
	// handshakes
	// ==============================
	assign s_axi_arready = (rd_state == r_idle);
	assign rd_accept     = s_axi_arvalid && s_axi_arready;

	// a read takes the request path first, the write lands one cycle later
	assign wr_accept = (wr_state == w_idle) && s_axi_awvalid && s_axi_wvalid && !rd_accept;

	assign s_axi_awready = wr_accept;  // aw and w taken together
	assign s_axi_wready  = wr_accept;

	assign s_axi_bvalid = (wr_state == w_resp);
	assign s_axi_bresp  = bresp_q;
	assign s_axi_rvalid = (rd_state == r_data);
	assign s_axi_rresp  = rresp_q;
	assign s_axi_rdata  = rd_in_range_q ? rd_data : '0;  // unmapped reads return 0

	// single cycle request into the register bank
	always_comb begin
		access.wr    = wr_accept && aw_in_range;
		access.rd    = rd_accept && ar_in_range;
		access.index = rd_accept ? s_axi_araddr[idx_w+1:2] : s_axi_awaddr[idx_w+1:2];
		access.wdata = s_axi_wdata;
		access.strb  = s_axi_wstrb;
	end

	// ==============================
	// write channel
	// ==============================
	always_ff @(posedge s_axi_aclk) begin
		if (reset) begin
			wr_state <= w_idle;
		end else begin
			case (wr_state)
				w_idle: begin
					if (wr_accept) begin
						wr_state <= w_resp;
					end
				end
				w_resp: begin
					if (s_axi_bready) begin
						wr_state <= w_idle;  // response taken
					end
				end
				default: wr_state <= w_idle;
			endcase
		end
	end

	always_ff @(posedge s_axi_aclk) begin
		if (wr_accept) begin
			bresp_q <= aw_in_range ? axi_okay : axi_slverr;
		end
	end

	// ==============================
	// read channel
	// ==============================
	always_ff @(posedge s_axi_aclk) begin
		if (reset) begin
			rd_state <= r_idle;
		end else begin
			case (rd_state)
				r_idle: begin
					if (rd_accept) begin
						rd_state <= r_data;
					end
				end
				r_data: begin
					if (s_axi_rready) begin
						rd_state <= r_idle;
					end
				end
				default: rd_state <= r_idle;
			endcase
		end
	end

	always_ff @(posedge s_axi_aclk) begin
		if (rd_accept) begin
			rresp_q       <= ar_in_range ? axi_okay : axi_slverr;
			rd_in_range_q <= ar_in_range;
		end
	end

endmodule

// File: verilog/link_config_regs.sv
`timescale 1ns/100ps

module link_config_regs (
	input  logic                                s_axi_aclk,
	input  logic                                reset,
	input  trigger_xbar_pkg::reg_access_t       access,
	output logic [trigger_xbar_pkg::data_w-1:0] rd_data,
	output trigger_xbar_pkg::link_table_t       link_table
);
	import trigger_xbar_pkg::*;

	link_param_t wr_link;
	link_param_t rd_link;

	// view the write data through the register layout
	assign wr_link = link_param_t'(access.wdata);

	// ==============================
	// link registers
	// ==============================
	// byte 0 holds the select, byte 2 the direction
	// bytes 1 and 3 are padding only and ignore their strobes
	always_ff @(posedge s_axi_aclk) begin
		if (reset) begin
			link_table <= link_defaults;
		end else if (access.wr) begin
			if (access.strb[0]) begin
				link_table[access.index].input_select <= wr_link.input_select;
			end
			if (access.strb[2]) begin
				link_table[access.index].direction <= wr_link.direction;
			end
		end
	end

	// ==============================
	// readback
	// ==============================
	always_comb begin
		rd_link              = link_table[access.index];
		rd_link.padding_high = '0;  // padding always reads 0
		rd_link.padding_low  = '0;
	end

	// captured on the request, stable until the next read
	always_ff @(posedge s_axi_aclk) begin
		if (access.rd) begin
			rd_data <= rd_link;
		end
	end

endmodule

// File: verilog/ext_trigger_pins.sv
`timescale 1ns/100ps

module ext_trigger_pins (
	input  logic                                    s_axi_aclk,
	input  logic                                    reset,
	input  logic [trigger_xbar_pkg::n_external-1:0] ext_in,
	output logic [trigger_xbar_pkg::n_external-1:0] ext_out,
	output logic [trigger_xbar_pkg::n_external-1:0] ext_oe,
	input  logic [trigger_xbar_pkg::n_external-1:0] dirs,
	input  logic [trigger_xbar_pkg::n_external-1:0] ext_drive,
	output logic [trigger_xbar_pkg::n_external-1:0] ext_sources
);
	import trigger_xbar_pkg::*;

	logic [n_external-1:0] sync_meta;
	logic [n_external-1:0] sync_q;

	// ==============================
	// input synchronizer
	// ==============================
	// pins are asynchronous to the bus clock
	always_ff @(posedge s_axi_aclk) begin
		if (reset) begin
			sync_meta <= '0;
			sync_q    <= '0;
		end else begin
			sync_meta <= ext_in;  // first stage may go metastable
			sync_q    <= sync_meta;
		end
	end

	// a pin driven by us is not a source
	assign ext_sources = sync_q & dirs;

	// ==============================
	// output side
	// ==============================
	assign ext_oe  = ~dirs;      // direction 1 is input, driver off
	assign ext_out = ext_drive;  // routed destinations 0-3

endmodule

// File: verilog/trigger_router.sv
`timescale 1ns/100ps

module trigger_router (
	input  logic                                   s_axi_aclk,
	input  logic                                   reset,
	input  logic [trigger_xbar_pkg::n_inputs-1:0]  sources,
	input  trigger_xbar_pkg::link_table_t          link_table,
	output logic [trigger_xbar_pkg::n_outputs-1:0] trigger_outputs
);
	import trigger_xbar_pkg::*;

	// every select code has an entry, unused codes read 0
	logic [2**sel_w-1:0] padded_sources;

	assign padded_sources = {{(2**sel_w-n_inputs){1'b0}}, sources};

	// ==============================
	// output multiplexers
	// ==============================
	// links n_outputs and above have no destination
	always_ff @(posedge s_axi_aclk) begin
		if (reset) begin
			trigger_outputs <= '0;
		end else begin
			for (int d = 0; d < n_outputs; d++) begin
				trigger_outputs[d] <= padded_sources[link_table[d].input_select];
			end
		end
	end

endmodule

// File: verilog/trigger_xbar.sv
`timescale 1ns/100ps

module trigger_xbar (
	input  logic                                    s_axi_aclk,
	input  logic                                    reset,
	input  logic [trigger_xbar_pkg::addr_w-1:0]     s_axi_awaddr,
	input  logic                                    s_axi_awvalid,
	output logic                                    s_axi_awready,
	input  logic [trigger_xbar_pkg::data_w-1:0]     s_axi_wdata,
	input  logic [trigger_xbar_pkg::data_w/8-1:0]   s_axi_wstrb,
	input  logic                                    s_axi_wvalid,
	output logic                                    s_axi_wready,
	output logic [1:0]                              s_axi_bresp,
	output logic                                    s_axi_bvalid,
	input  logic                                    s_axi_bready,
	input  logic [trigger_xbar_pkg::addr_w-1:0]     s_axi_araddr,
	input  logic                                    s_axi_arvalid,
	output logic                                    s_axi_arready,
	output logic [trigger_xbar_pkg::data_w-1:0]     s_axi_rdata,
	output logic [1:0]                              s_axi_rresp,
	output logic                                    s_axi_rvalid,
	input  logic                                    s_axi_rready,
	input  logic                                    l1a,        // from fast command decoder
	input  logic                                    self_trig,  // from self trigger logic
	input  logic [trigger_xbar_pkg::n_external-1:0] ext_in,
	output logic [trigger_xbar_pkg::n_external-1:0] ext_out,
	output logic [trigger_xbar_pkg::n_external-1:0] ext_oe,
	output logic [trigger_xbar_pkg::n_outputs-1:0]  trigger_outputs
);
	import trigger_xbar_pkg::*;

	reg_access_t           access;
	logic [data_w-1:0]     rd_data;
	link_table_t           link_table;
	logic [n_external-1:0] dirs;
	logic [n_external-1:0] ext_sources;
	logic [n_inputs-1:0]   sources;

	// source order: ext pins 0-3, l1a, self trigger
	assign sources = {self_trig, l1a, ext_sources};

	// only the first links steer pins
	always_comb begin
		for (int i = 0; i < n_external; i++) begin
			dirs[i] = link_table[i].direction;
		end
	end

	// ==============================
	// bus side
	// ==============================
	axil_reg_slave u_slave (
		.s_axi_aclk(s_axi_aclk), .reset(reset),
		.s_axi_awaddr(s_axi_awaddr), .s_axi_awvalid(s_axi_awvalid),
		.s_axi_awready(s_axi_awready), .s_axi_wdata(s_axi_wdata),
		.s_axi_wstrb(s_axi_wstrb), .s_axi_wvalid(s_axi_wvalid),
		.s_axi_wready(s_axi_wready), .s_axi_bresp(s_axi_bresp),
		.s_axi_bvalid(s_axi_bvalid), .s_axi_bready(s_axi_bready),
		.s_axi_araddr(s_axi_araddr), .s_axi_arvalid(s_axi_arvalid),
		.s_axi_arready(s_axi_arready), .s_axi_rdata(s_axi_rdata),
		.s_axi_rresp(s_axi_rresp), .s_axi_rvalid(s_axi_rvalid),
		.s_axi_rready(s_axi_rready), .access(access), .rd_data(rd_data)
	);

	link_config_regs u_regs (
		.s_axi_aclk(s_axi_aclk), .reset(reset), .access(access),
		.rd_data(rd_data), .link_table(link_table)
	);

	// ==============================
	// trigger side
	// ==============================
	ext_trigger_pins u_pins (
		.s_axi_aclk(s_axi_aclk), .reset(reset), .ext_in(ext_in),
		.ext_out(ext_out), .ext_oe(ext_oe), .dirs(dirs),
		.ext_drive(trigger_outputs[n_external-1:0]), .ext_sources(ext_sources)
	);

	trigger_router u_router (
		.s_axi_aclk(s_axi_aclk), .reset(reset), .sources(sources),
		.link_table(link_table), .trigger_outputs(trigger_outputs)
	);

endmodule

// File: bench/trigger_xbar_tb.sv
`timescale 1ns/100ps

module trigger_xbar_tb;
	import trigger_xbar_pkg::*;

	localparam int n_tests  = 6;
	localparam int clk_ns   = 10;
	localparam int test_ns  = 2000;
	localparam int limit_ns = 10 * clk_ns + n_tests * test_ns + 1000;  // reset, tests, margin
	localparam int wait_max = 32;  // cycles allowed for one handshake

	logic                  clk;
	logic                  reset;
	logic [addr_w-1:0]     awaddr;
	logic                  awvalid;
	logic                  awready;
	logic [data_w-1:0]     wdata;
	logic [data_w/8-1:0]   wstrb;
	logic                  wvalid;
	logic                  wready;
	logic [1:0]            bresp;
	logic                  bvalid;
	logic                  bready;
	logic [addr_w-1:0]     araddr;
	logic                  arvalid;
	logic                  arready;
	logic [data_w-1:0]     rdata;
	logic [1:0]            rresp;
	logic                  rvalid;
	logic                  rready;
	logic                  l1a;
	logic                  self_trig;
	logic [n_external-1:0] ext_in;
	logic [n_external-1:0] ext_out;
	logic [n_external-1:0] ext_oe;
	logic [n_outputs-1:0]  trigger_outputs;

	int                    errors;
	int                    failed_tests;
	int                    test_errors_start;
	logic [31:0]           rng;
	logic                  toggle_en;

	logic [3:0]            model_sel [n_links];
	logic                  model_dir [n_links];
	logic [n_external-1:0] model_dirs;
	logic [n_external-1:0] sync1;
	logic [n_external-1:0] sync2;
	logic [n_inputs-1:0]   model_sources;
	logic [n_outputs-1:0]  exp_route;
	logic                  pend_wr;
	logic [3:0]            pend_index;
	logic [31:0]           pend_data;
	logic [3:0]            pend_strb;

	trigger_xbar UUT (
		.s_axi_aclk(clk), .reset(reset),
		.s_axi_awaddr(awaddr), .s_axi_awvalid(awvalid), .s_axi_awready(awready),
		.s_axi_wdata(wdata), .s_axi_wstrb(wstrb), .s_axi_wvalid(wvalid),
		.s_axi_wready(wready), .s_axi_bresp(bresp), .s_axi_bvalid(bvalid),
		.s_axi_bready(bready), .s_axi_araddr(araddr), .s_axi_arvalid(arvalid),
		.s_axi_arready(arready), .s_axi_rdata(rdata), .s_axi_rresp(rresp),
		.s_axi_rvalid(rvalid), .s_axi_rready(rready), .l1a(l1a), .self_trig(self_trig),
		.ext_in(ext_in), .ext_out(ext_out), .ext_oe(ext_oe),
		.trigger_outputs(trigger_outputs)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_ns / 2) clk = ~clk;
	end

	function automatic logic [31:0] lcg_next();
		rng = rng * 32'd1664525 + 32'd1013904223;
		return rng;
	endfunction

	// links 0-4 quiet, 5-7 take pins 1-3, the rest pin 0
	function automatic logic [3:0] default_select(int link);
		if (link <= 4) begin
			return 4'd6;
		end else if (link <= 7) begin
			return 4'(link - 4);
		end
		return 4'd0;
	endfunction

	function automatic logic [31:0] model_word(int link);
		return {15'd0, model_dir[link], 12'd0, model_sel[link]};
	endfunction

	// ==============================
	// reference model
	// ==============================
	// handshake seen mid cycle, applied on the edge that accepts it
	always @(negedge clk) begin
		pend_wr    = !reset && awvalid && awready && wvalid && wready && (awaddr < 11'd64);
		pend_index = awaddr[5:2];
		pend_data  = wdata;
		pend_strb  = wstrb;
	end

	always @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < n_links; i++) begin
				model_sel[i] <= default_select(i);
				model_dir[i] <= 1'b1;
			end
			sync1 <= '0;
			sync2 <= '0;
		end else begin
			if (pend_wr && pend_strb[0]) begin
				model_sel[pend_index] <= pend_data[3:0];
			end
			if (pend_wr && pend_strb[2]) begin
				model_dir[pend_index] <= pend_data[16];
			end
			sync1 <= ext_in;  // two flop pin synchronizer
			sync2 <= sync1;
		end
	end

	always_comb begin
		for (int i = 0; i < n_external; i++) begin
			model_dirs[i] = model_dir[i];
		end
		model_sources = {self_trig, l1a, sync2 & model_dirs};  // output pins read 0
		for (int d = 0; d < n_outputs; d++) begin
			if (model_sel[d] < 4'd6) begin
				exp_route[d] = model_sources[model_sel[d][2:0]];
			end else begin
				exp_route[d] = 1'b0;
			end
		end
	end

	// random source activity, one new pattern per cycle
	always @(posedge clk) begin
		logic [31:0] stim;
		if (toggle_en) begin
			stim = lcg_next();  // drawn on the edge, driven just after it
			#1;
			l1a       = stim[4];
			self_trig = stim[5];
			ext_in    = stim[11:8];
		end
	end

	// ==============================
	// assertions
	// ==============================
	generate
		for (genvar d = 0; d < n_outputs; d++) begin : g_route
			route_check: assert property (@(posedge clk) disable iff (reset)
				trigger_outputs[d] == $past(exp_route[d]))
			else begin
				errors++;
				$display("Error at %0t ns: destination %0d does not follow its source", $time, d);
			end
		end
	endgenerate

	pin_oe_check: assert property (@(posedge clk) disable iff (reset) ext_oe == ~model_dirs)
	else begin
		errors++;
		$display("Error at %0t ns: ext_oe does not match the pin directions", $time);
	end

	pin_out_check: assert property (@(posedge clk) disable iff (reset)
		ext_out == $past(exp_route[n_external-1:0]))
	else begin
		errors++;
		$display("Error at %0t ns: ext_out does not carry destinations 0-3", $time);
	end

	b_hold_check: assert property (@(posedge clk) disable iff (reset)
		(bvalid && !bready) |=> bvalid)
	else begin
		errors++;
		$display("Error at %0t ns: bvalid dropped before bready", $time);
	end

	r_hold_check: assert property (@(posedge clk) disable iff (reset)
		(rvalid && !rready) |=> rvalid)
	else begin
		errors++;
		$display("Error at %0t ns: rvalid dropped before rready", $time);
	end

	w_block_check: assert property (@(posedge clk) disable iff (reset)
		bvalid |-> (!awready && !wready))
	else begin
		errors++;
		$display("Error at %0t ns: write accepted while a response is pending", $time);
	end

	r_block_check: assert property (@(posedge clk) disable iff (reset) rvalid |-> !arready)
	else begin
		errors++;
		$display("Error at %0t ns: arready high while read data is pending", $time);
	end

	// ==============================
	// bus master tasks
	// ==============================
	task automatic start_write(input logic [10:0] addr, input logic [31:0] data,
			input logic [3:0] strb);
		awaddr  = addr;
		wdata   = data;
		wstrb   = strb;
		awvalid = 1'b1;
		wvalid  = 1'b1;
	endtask

	task automatic wait_write_accept();
		int   n;
		logic hs;
		n  = 0;
		hs = 1'b0;
		while (!hs && n < wait_max) begin
			@(negedge clk);
			hs = awready && wready;
			@(posedge clk);
			#1;
			n++;
		end
		if (!hs) begin
			errors++;
			$display("timeout: the DUT did not accept a write at %0t ns", $time);
		end
	endtask

	task automatic wait_write_resp(output logic [1:0] resp);
		int   n;
		logic hs;
		n     = 0;
		hs    = 1'b0;
		resp  = 2'b11;
		bready = 1'b1;
		while (!hs && n < wait_max) begin
			@(negedge clk);
			hs   = bvalid;
			resp = bresp;
			@(posedge clk);
			#1;
			n++;
		end
		bready = 1'b0;
		if (!hs) begin
			errors++;
			$display("timeout: no write response from the DUT at %0t ns", $time);
		end
	endtask

	task automatic axil_write(input logic [10:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output logic [1:0] resp);
		start_write(addr, data, strb);
		wait_write_accept();
		awvalid = 1'b0;
		wvalid  = 1'b0;
		wait_write_resp(resp);
	endtask

	task automatic axil_read(input logic [10:0] addr, input int stall,
			output logic [31:0] data, output logic [1:0] resp);
		int   n;
		logic hs;
		araddr  = addr;
		arvalid = 1'b1;
		n       = 0;
		hs      = 1'b0;
		while (!hs && n < wait_max) begin
			@(negedge clk);
			hs = arready;
			@(posedge clk);
			#1;
			n++;
		end
		arvalid = 1'b0;
		repeat (stall) begin
			@(posedge clk);
			#1;
		end
		rready = 1'b1;
		n      = 0;
		hs     = 1'b0;
		while (!hs && n < wait_max) begin
			@(negedge clk);
			hs   = rvalid;
			data = rdata;
			resp = rresp;
			@(posedge clk);
			#1;
			n++;
		end
		rready = 1'b0;
		if (!hs) begin
			errors++;
			$display("timeout: read at address %0d got no data from the DUT", addr);
		end
	endtask

	// ==============================
	// checks and reporting
	// ==============================
	task automatic check_resp(input logic [1:0] got, input logic [1:0] want, input string what);
		assert (got == want)
		else begin
			errors++;
			$display("Error at %0t ns: %s response %b, expected %b", $time, what, got, want);
		end
	endtask

	task automatic check_readback(input int link);
		logic [31:0] data;
		logic [1:0]  resp;
		axil_read({5'd0, link[3:0], 2'b00}, 0, data, resp);
		check_resp(resp, 2'b00, "read");
		assert (data == model_word(link))
		else begin
			errors++;
			$display("Error at %0t ns: link %0d reads %h, expected %h", $time, link, data,
				model_word(link));
		end
	endtask

	task automatic check_table();
		for (int i = 0; i < n_links; i++) begin
			check_readback(i);
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic finish_test(input int num, input string name);
		int n;
		n = errors - test_errors_start;
		if (n > 0) begin
			failed_tests++;
		end
		$display("test %0d %s done with %0d errors", num, name, n);
		test_errors_start = errors;
	endtask

	// ==============================
	// test sequence
	// ==============================
	initial begin
		logic [31:0] r;
		logic [31:0] data;
		logic [1:0]  resp;
		logic [10:0] addr;
		int          link;
		$timeformat(-9, 0, "", 0);
		errors            = 0;
		failed_tests      = 0;
		test_errors_start = 0;
		rng               = 32'h4883acbe;
		toggle_en         = 1'b0;
		reset             = 1'b1;
		awaddr            = '0;
		awvalid           = 1'b0;
		wdata             = '0;
		wstrb             = '0;
		wvalid            = 1'b0;
		bready            = 1'b0;
		araddr            = '0;
		arvalid           = 1'b0;
		rready            = 1'b0;
		l1a               = 1'b0;
		self_trig         = 1'b0;
		ext_in            = '0;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;

		idle_cycles(2);
		@(negedge clk);
		assert (ext_oe == '0 && trigger_outputs == '0)
		else begin
			errors++;
			$display("Error at %0t ns: outputs not idle after reset", $time);
		end
		idle_cycles(1);
		check_table();
		finish_test(1, "reset");

		toggle_en = 1'b1;
		repeat (16) begin
			r = lcg_next();
			axil_write({5'd0, r[3:0], 2'b00}, lcg_next(), r[7:4], resp);
			check_resp(resp, 2'b00, "write");
			check_readback(int'(r[3:0]));
		end
		finish_test(2, "register access");

		for (int i = 0; i < n_external; i++) begin
			axil_write({5'd0, i[3:0], 2'b00}, 32'h0001_0000, 4'b0100, resp);  // pin as input
		end
		repeat (12) begin
			r    = lcg_next();
			link = int'(r[3:0]) % n_outputs;
			axil_write({5'd0, link[3:0], 2'b00}, {29'd0, r[10:8]}, 4'b0001, resp);
			check_resp(resp, 2'b00, "write");
			idle_cycles(6);
		end
		finish_test(3, "routing");

		for (int i = 0; i < n_external; i++) begin
			axil_write({5'd0, i[3:0], 2'b00}, 32'h0000_0004, 4'b0101, resp);  // drive l1a out
			link = i + 5;
			axil_write({5'd0, link[3:0], 2'b00}, {28'd0, i[3:0]}, 4'b0001, resp);
		end
		idle_cycles(10);
		@(negedge clk);
		assert (ext_oe == 4'hf)
		else begin
			errors++;
			$display("Error at %0t ns: ext_oe is %b with all pins as outputs", $time, ext_oe);
		end
		idle_cycles(1);
		axil_write(11'd0, 32'h0001_0000, 4'b0100, resp);
		axil_write(11'd4, 32'h0001_0000, 4'b0100, resp);
		idle_cycles(10);
		finish_test(4, "direction");

		repeat (4) begin
			r    = lcg_next();
			addr = r[10:0] | 11'h040;  // always 64 or more
			axil_write(addr, lcg_next(), 4'hf, resp);
			check_resp(resp, 2'b10, "unmapped write");
			axil_read(addr, 0, data, resp);
			check_resp(resp, 2'b10, "unmapped read");
			assert (data == 32'd0)
			else begin
				errors++;
				$display("Error at %0t ns: unmapped read returned %h", $time, data);
			end
		end
		check_table();
		finish_test(5, "out of range");

		start_write(11'd8, 32'h0000_0004, 4'b0101);
		wait_write_accept();
		start_write(11'd28, 32'h0000_0005, 4'b0001);  // queued behind the stalled response
		idle_cycles(6);
		wait_write_resp(resp);
		check_resp(resp, 2'b00, "stalled write");
		wait_write_accept();
		awvalid = 1'b0;
		wvalid  = 1'b0;
		wait_write_resp(resp);
		check_resp(resp, 2'b00, "queued write");
		axil_read(11'd28, 6, data, resp);
		check_resp(resp, 2'b00, "stalled read");
		assert (data == model_word(7))
		else begin
			errors++;
			$display("Error at %0t ns: stalled read returned %h", $time, data);
		end
		check_readback(2);
		finish_test(6, "back-pressure");

		toggle_en = 1'b0;
		$display("tests %0d, failed %0d, errors %0d", n_tests, failed_tests, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// run limit from the test count
	initial begin
		#(limit_ns);
		$display("timeout: the tests did not finish within %0d ns", limit_ns);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: flist.f
verilog/trigger_xbar_pkg.sv
verilog/axil_reg_slave.sv
verilog/link_config_regs.sv
verilog/ext_trigger_pins.sv
verilog/trigger_router.sv
verilog/trigger_xbar.sv
bench/trigger_xbar_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the trigger crossbar testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
	--top-module trigger_xbar_tb \
	-f flist.f \
	-o trigger_xbar_sim

./obj_dir/trigger_xbar_sim > sim.log 2>&1
cat sim.log

if grep -qx "=== PASS ===" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
